// File: logic/iigs_mem_pkg.sv
`default_nettype none

package iigs_mem_pkg;

  // cpu side address widths
  localparam int bank_w = 8;
  localparam int addr_w = 16;

  // slow ram is banks e0/e1, so bank bit 0 plus the in-bank address
  localparam int slow_aw = 17;
  // fast ram is bank bits 6:0 plus the in-bank address
  localparam int fast_aw = 23;
  localparam int fast_banks = 20;

  localparam logic [bank_w-1:0] rom_bank = 8'hfe;
  localparam logic [bank_w-1:0] rom_hi_bank = 8'hff;

  // video fetch length per scanline
  localparam int line_bytes = 40;
  localparam int line_cnt_w = $clog2(line_bytes);
  localparam logic [line_cnt_w-1:0] last_byte = line_cnt_w'(line_bytes - 1);

  // what an access to unmapped space reads back
  localparam logic [7:0] float_byte = 8'h80;

  // access target codes, registered at the strobe for the read mux
  localparam int tgt_w = 3;
  localparam logic [tgt_w-1:0] tgt_none = 3'd0;
  localparam logic [tgt_w-1:0] tgt_rom = 3'd1;
  localparam logic [tgt_w-1:0] tgt_fast = 3'd2;
  localparam logic [tgt_w-1:0] tgt_slow = 3'd3;
  localparam logic [tgt_w-1:0] tgt_slot = 3'd4;

  // in-bank cpu address, decoded as slot rom or as slot device registers
  typedef union packed {
    logic [addr_w-1:0] flat;
    // c400-c7ff, one 256 byte page per slot
    struct packed {
      logic [4:0] page;
      logic [2:0] num;
      logic [7:0] offset;
    } slot;
    // c090-c0ff, sixteen registers per slot device
    struct packed {
      logic [8:0] upper;
      logic [2:0] num;
      logic [3:0] reg_sel;
    } dev;
  } cpu_addr_u;

endpackage

`default_nettype wire

// File: logic/bank_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bank_decoder
(
  input  wire                                  clk_sys,
  input  wire                                  arst_n,
  input  wire                                  cpu_strobe,
  input  wire [iigs_mem_pkg::bank_w-1:0]       bank,
  input  wire [iigs_mem_pkg::addr_w-1:0]       addr,
  input  wire                                  we,
  input  wire [7:0]                            cpu_dout,
  input  wire [7:0]                            shadow,
  input  wire                                  lc_ram2,
  input  wire                                  lc_we,
  input  wire                                  rd_rom,
  input  wire                                  cx_rom,
  input  wire                                  io_on,
  input  wire [7:0]                            slot_rom_sel,
  input  wire [7:0]                            rom_rdata,
  input  wire [7:0]                            fast_rdata,
  input  wire [7:0]                            slow_rdata,
  input  wire [7:0]                            slot_rdata,
  output logic                                 rom_ce,
  output logic [iigs_mem_pkg::addr_w:0]        rom_addr,
  output logic                                 fast_ce,
  output logic [iigs_mem_pkg::fast_aw-1:0]     fast_addr,
  output logic                                 fast_we,
  output logic [7:0]                           fast_wdata,
  output logic                                 cpu_slow_req,
  output logic [iigs_mem_pkg::slow_aw-1:0]     cpu_slow_addr,
  output logic                                 cpu_slow_we,
  output logic [7:0]                           cpu_slow_wdata,
  output logic [7:0]                           io_select,
  output logic [7:0]                           device_select,
  output logic [7:0]                           cpu_din
);

  iigs_mem_pkg::cpu_addr_u a;
  logic [iigs_mem_pkg::addr_w-1:0] raddr;
  logic [iigs_mem_pkg::tgt_w-1:0] tgt;
  logic [iigs_mem_pkg::tgt_w-1:0] tgt_q;
  logic bank_00, bank_01, bank_e, bank_mirror, bank_rom;
  logic in_cxxx, in_dxxx, in_exxx, in_slot_rom, in_dev;
  logic rom_hit, wt_hit, fast_hit, shadow_hit, io_hit, dev_hit;

  assign a = addr;

  // banks 00/01 and their slow ram images e0/e1 share the i/o window
  assign bank_00 = (bank == 8'h00);
  assign bank_01 = (bank == 8'h01);
  assign bank_e = (bank == 8'he0) || (bank == 8'he1);
  assign bank_mirror = bank_00 || bank_01 || bank_e;
  assign bank_rom = (bank == iigs_mem_pkg::rom_bank);

  assign in_cxxx = (addr[15:12] == 4'hc);
  assign in_dxxx = (addr[15:12] == 4'hd);
  assign in_exxx = (addr[15:13] == 3'b111);
  assign in_slot_rom = (a.flat >= 16'hc400) && (a.flat <= 16'hc7ff);
  assign in_dev = (a.flat >= 16'hc090) && (a.flat <= 16'hc0ff);

  // language card writes with lc_we go to ram even while rom is read
  assign wt_hit = bank_00 && in_dxxx && lc_we && we;

  assign rom_hit = bank_rom ||
                   ((bank == iigs_mem_pkg::rom_hi_bank) ||
                    (bank_00 && (in_cxxx || in_exxx || (in_dxxx && rd_rom))))
                   && !wt_hit;

  assign fast_hit = (bank < iigs_mem_pkg::fast_banks) && !io_on;

  // shadow bits are active low, bank 01 also needs bit 4 clear except for shr
  always_comb
  begin
    shadow_hit = 1'b0;
    if (bank_00 || bank_01)
    begin
      if (in_cxxx && !shadow[6])
        shadow_hit = 1'b1;
      // text page 1
      else if (addr >= 16'h0400 && addr <= 16'h07ff)
        shadow_hit = !shadow[0] && (bank_00 || !shadow[4]);
      // text page 2
      else if (addr >= 16'h0800 && addr <= 16'h0bff)
        shadow_hit = !shadow[5] && (bank_00 || !shadow[4]);
      // hires page 1, also part of super hires
      else if (addr >= 16'h2000 && addr <= 16'h3fff)
        shadow_hit = (!shadow[1] && (bank_00 || !shadow[4])) || !shadow[3];
      // hires page 2, also part of super hires
      else if (addr >= 16'h4000 && addr <= 16'h5fff)
        shadow_hit = (!shadow[2] && (bank_00 || !shadow[4])) || !shadow[3];
    end
  end

  // a set slot_rom_sel bit keeps internal firmware on that slot
  assign io_hit = bank_mirror && in_slot_rom && !slot_rom_sel[a.slot.num] && !cx_rom;
  assign dev_hit = bank_mirror && in_dev && !slot_rom_sel[a.dev.num];

  // priority order of the memory map
  always_comb
  begin
    if (rom_hit)
      tgt = iigs_mem_pkg::tgt_rom;
    else if (fast_hit)
      tgt = iigs_mem_pkg::tgt_fast;
    else if (bank_e || shadow_hit)
      tgt = iigs_mem_pkg::tgt_slow;
    else if (io_hit || dev_hit)
      tgt = iigs_mem_pkg::tgt_slot;
    else
      tgt = iigs_mem_pkg::tgt_none;
  end

  // language card bank 2 sits 4k below d000
  assign raddr = (bank_mirror && in_dxxx && lc_ram2) ? addr - 16'h1000 : addr;

  // fe reads rom half 0, ff and the bank 00 windows read half 1
  assign rom_ce = cpu_strobe && (tgt == iigs_mem_pkg::tgt_rom);
  assign rom_addr = {!bank_rom, addr};

  assign fast_ce = cpu_strobe && (tgt == iigs_mem_pkg::tgt_fast);
  assign fast_we = fast_ce && we;
  assign fast_addr = {bank[6:0], raddr};
  assign fast_wdata = cpu_dout;

  // shadowed writes into fast ram are copied to slow ram as well
  assign cpu_slow_req = cpu_strobe &&
                        ((tgt == iigs_mem_pkg::tgt_slow) ||
                         ((tgt == iigs_mem_pkg::tgt_fast) && we && shadow_hit));
  assign cpu_slow_addr = {bank[0], raddr};
  assign cpu_slow_we = we;
  assign cpu_slow_wdata = cpu_dout;

  // one-hot card strobes, only in the strobe cycle
  always_comb
  begin
    io_select = 8'h00;
    device_select = 8'h00;
    if (cpu_strobe && io_hit)
      io_select[a.slot.num] = 1'b1;
    if (cpu_strobe && dev_hit)
      device_select[a.dev.num] = 1'b1;
  end

  always_ff @(posedge clk_sys or negedge arst_n)
  begin
    if (!arst_n)
      tgt_q <= iigs_mem_pkg::tgt_none;
    else if (cpu_strobe)
      tgt_q <= tgt;
  end

  // every source answers one cycle after the strobe
  always_comb
  begin
    case (tgt_q)
      iigs_mem_pkg::tgt_rom:  cpu_din = rom_rdata;
      iigs_mem_pkg::tgt_fast: cpu_din = fast_rdata;
      iigs_mem_pkg::tgt_slow: cpu_din = slow_rdata;
      iigs_mem_pkg::tgt_slot: cpu_din = slot_rdata;
      default:                cpu_din = iigs_mem_pkg::float_byte;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/slow_ram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module slow_ram_arbiter
(
  input  wire                                  clk_sys,
  input  wire                                  arst_n,
  input  wire                                  cpu_strobe,
  input  wire                                  cpu_slow_req,
  input  wire [iigs_mem_pkg::slow_aw-1:0]      cpu_slow_addr,
  input  wire                                  cpu_slow_we,
  input  wire [7:0]                            cpu_slow_wdata,
  input  wire                                  vid_req,
  input  wire [iigs_mem_pkg::slow_aw-1:0]      vid_addr,
  input  wire [7:0]                            ram_rdata,
  output logic                                 vid_grant,
  output logic                                 ram_ce,
  output logic [iigs_mem_pkg::slow_aw-1:0]     ram_addr,
  output logic                                 ram_we,
  output logic [7:0]                           ram_wdata,
  output logic [7:0]                           cpu_rdata,
  output logic [7:0]                           vid_rdata,
  output logic                                 vid_rvalid
);

  logic cpu_go;
  logic cpu_own_q;
  logic vid_own_q;
  logic [7:0] cpu_hold_q;

  // cpu always wins in its strobe cycle, video takes the idle cycles
  assign cpu_go = cpu_strobe && cpu_slow_req;
  assign vid_grant = vid_req && !cpu_go;

  assign ram_ce = cpu_go || vid_grant;
  assign ram_addr = cpu_go ? cpu_slow_addr : vid_addr;
  assign ram_we = cpu_go && cpu_slow_we;
  assign ram_wdata = cpu_slow_wdata;

  // owner of the byte coming back next cycle, writes return nothing
  always_ff @(posedge clk_sys or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cpu_own_q <= 1'b0;
      vid_own_q <= 1'b0;
    end
    else
    begin
      cpu_own_q <= cpu_go && !cpu_slow_we;
      vid_own_q <= vid_grant;
    end
  end

  // keep the last cpu byte so later video reads do not disturb it
  always_ff @(posedge clk_sys)
  begin
    if (cpu_own_q)
      cpu_hold_q <= ram_rdata;
  end

  assign cpu_rdata = cpu_own_q ? ram_rdata : cpu_hold_q;
  assign vid_rdata = ram_rdata;
  assign vid_rvalid = vid_own_q;

endmodule

`default_nettype wire

// File: logic/slow_ram.sv
`timescale 1ns/1ps
`default_nettype none

module slow_ram
(
  input  wire                                  clk_sys,
  input  wire                                  ce,
  input  wire [iigs_mem_pkg::slow_aw-1:0]      addr,
  input  wire                                  we,
  input  wire [7:0]                            wdata,
  output logic [7:0]                           rdata
);

  // banks e0 and e1, 128k bytes
  logic [7:0] mem [0:(2**iigs_mem_pkg::slow_aw)-1];

  // single port, read returns the old byte on a write
  always_ff @(posedge clk_sys)
  begin
    if (ce)
    begin
      if (we)
        mem[addr] <= wdata;
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

// File: logic/video_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module video_fetch
(
  input  wire                                  clk_sys,
  input  wire                                  arst_n,
  input  wire                                  line_start,
  input  wire [iigs_mem_pkg::slow_aw-1:0]      vid_base,
  input  wire                                  vid_grant,
  input  wire [7:0]                            vid_rdata,
  input  wire                                  vid_rvalid,
  output logic                                 vid_req,
  output logic [iigs_mem_pkg::slow_aw-1:0]     vid_addr,
  output logic [7:0]                           vid_data,
  output logic                                 vid_valid
);

  logic req_q;
  logic tail_q;
  logic last_grant;
  logic [iigs_mem_pkg::line_cnt_w-1:0] cnt_q;
  logic [iigs_mem_pkg::slow_aw-1:0] addr_q;

  assign last_grant = vid_grant && (cnt_q == iigs_mem_pkg::last_byte);

  // req_q covers the grants, tail_q the final byte still in flight
  always_ff @(posedge clk_sys or negedge arst_n)
  begin
    if (!arst_n)
    begin
      req_q <= 1'b0;
      tail_q <= 1'b0;
      cnt_q <= '0;
    end
    else
    begin
      tail_q <= last_grant;
      if (line_start && !req_q && !tail_q)
      begin
        req_q <= 1'b1;
        cnt_q <= '0;
      end
      else if (vid_grant)
      begin
        cnt_q <= cnt_q + 1'b1;
        if (last_grant)
          req_q <= 1'b0;
      end
    end
  end

  // line address, loaded at line start and stepped per grant
  always_ff @(posedge clk_sys)
  begin
    if (line_start && !req_q && !tail_q)
      addr_q <= vid_base;
    else if (vid_grant)
      addr_q <= addr_q + 1'b1;
  end

  assign vid_req = req_q;
  assign vid_addr = addr_q;

  // each returned video byte belongs to the running line
  assign vid_data = vid_rdata;
  assign vid_valid = vid_rvalid;

endmodule

`default_nettype wire

// File: logic/iigs_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module iigs_mem_top
(
  input  wire                                  clk_sys,
  input  wire                                  arst_n,
  input  wire                                  cpu_strobe,
  input  wire [iigs_mem_pkg::bank_w-1:0]       bank,
  input  wire [iigs_mem_pkg::addr_w-1:0]       addr,
  input  wire                                  we,
  input  wire [7:0]                            cpu_dout,
  input  wire [7:0]                            shadow,
  input  wire                                  lc_ram2,
  input  wire                                  lc_we,
  input  wire                                  rd_rom,
  input  wire                                  cx_rom,
  input  wire                                  io_on,
  input  wire [7:0]                            slot_rom_sel,
  output logic                                 rom_ce,
  output logic [iigs_mem_pkg::addr_w:0]        rom_addr,
  input  wire [7:0]                            rom_rdata,
  output logic                                 fast_ce,
  output logic [iigs_mem_pkg::fast_aw-1:0]     fast_addr,
  output logic                                 fast_we,
  output logic [7:0]                           fast_wdata,
  input  wire [7:0]                            fast_rdata,
  input  wire [7:0]                            slot_rdata,
  output logic [7:0]                           io_select,
  output logic [7:0]                           device_select,
  output logic [7:0]                           cpu_din,
  input  wire                                  line_start,
  input  wire [iigs_mem_pkg::slow_aw-1:0]      vid_base,
  output logic [7:0]                           vid_data,
  output logic                                 vid_valid
);

  // cpu path into the arbiter
  logic cpu_slow_req, cpu_slow_we;
  logic [iigs_mem_pkg::slow_aw-1:0] cpu_slow_addr;
  logic [7:0] cpu_slow_wdata, slow_rdata;
  // video path into the arbiter
  logic vid_req, vid_grant, vid_rvalid;
  logic [iigs_mem_pkg::slow_aw-1:0] vid_addr;
  logic [7:0] vid_rdata;
  // slow ram port
  logic ram_ce, ram_we;
  logic [iigs_mem_pkg::slow_aw-1:0] ram_addr;
  logic [7:0] ram_wdata, ram_rdata;

  bank_decoder i_bank_decoder (
    .clk_sys(clk_sys), .arst_n(arst_n), .cpu_strobe(cpu_strobe), .bank(bank),
    .addr(addr), .we(we), .cpu_dout(cpu_dout), .shadow(shadow), .lc_ram2(lc_ram2),
    .lc_we(lc_we), .rd_rom(rd_rom), .cx_rom(cx_rom), .io_on(io_on),
    .slot_rom_sel(slot_rom_sel), .rom_rdata(rom_rdata), .fast_rdata(fast_rdata),
    .slow_rdata(slow_rdata), .slot_rdata(slot_rdata), .rom_ce(rom_ce),
    .rom_addr(rom_addr), .fast_ce(fast_ce), .fast_addr(fast_addr), .fast_we(fast_we),
    .fast_wdata(fast_wdata), .cpu_slow_req(cpu_slow_req), .cpu_slow_addr(cpu_slow_addr),
    .cpu_slow_we(cpu_slow_we), .cpu_slow_wdata(cpu_slow_wdata), .io_select(io_select),
    .device_select(device_select), .cpu_din(cpu_din)
  );

  slow_ram_arbiter i_slow_ram_arbiter (
    .clk_sys(clk_sys), .arst_n(arst_n), .cpu_strobe(cpu_strobe),
    .cpu_slow_req(cpu_slow_req), .cpu_slow_addr(cpu_slow_addr),
    .cpu_slow_we(cpu_slow_we), .cpu_slow_wdata(cpu_slow_wdata), .vid_req(vid_req),
    .vid_addr(vid_addr), .ram_rdata(ram_rdata), .vid_grant(vid_grant),
    .ram_ce(ram_ce), .ram_addr(ram_addr), .ram_we(ram_we), .ram_wdata(ram_wdata),
    .cpu_rdata(slow_rdata), .vid_rdata(vid_rdata), .vid_rvalid(vid_rvalid)
  );

  slow_ram i_slow_ram (
    .clk_sys(clk_sys), .ce(ram_ce), .addr(ram_addr), .we(ram_we),
    .wdata(ram_wdata), .rdata(ram_rdata)
  );

  video_fetch i_video_fetch (
    .clk_sys(clk_sys), .arst_n(arst_n), .line_start(line_start), .vid_base(vid_base),
    .vid_grant(vid_grant), .vid_rdata(vid_rdata), .vid_rvalid(vid_rvalid),
    .vid_req(vid_req), .vid_addr(vid_addr), .vid_data(vid_data), .vid_valid(vid_valid)
  );

endmodule

`default_nettype wire

// File: testbench/iigs_mem_chk.sv
`timescale 1ns/1ps
`default_nettype none

module iigs_mem_chk
(
  input wire                              clk_sys,
  input wire                              arst_n,
  input wire                              cpu_strobe,
  input wire                              cpu_slow_req,
  input wire [iigs_mem_pkg::slow_aw-1:0]  cpu_slow_addr,
  input wire                              vid_grant,
  input wire                              ram_ce,
  input wire [iigs_mem_pkg::slow_aw-1:0]  ram_addr,
  input wire                              vid_rvalid
);

  // cpu and video never share the port in one cycle
  one_owner: assert property (@(posedge clk_sys) disable iff (!arst_n)
    !(cpu_strobe && cpu_slow_req && vid_grant))
    else $error("slow ram port owned by cpu and video in the same cycle");

  // a strobe with a slow request always wins the port
  cpu_first: assert property (@(posedge clk_sys) disable iff (!arst_n)
    (cpu_strobe && cpu_slow_req) |-> (ram_ce && ram_addr == cpu_slow_addr))
    else $error("cpu strobe with slow request did not get the port");

  // returned video byte one cycle after each grant, and only then
  vid_return: assert property (@(posedge clk_sys) disable iff (!arst_n)
    vid_grant |=> vid_rvalid)
    else $error("video grant not followed by vid_rvalid");

  no_stray_valid: assert property (@(posedge clk_sys) disable iff (!arst_n)
    vid_rvalid |-> $past(vid_grant))
    else $error("vid_rvalid without a video grant in the cycle before");

endmodule

bind slow_ram_arbiter iigs_mem_chk i_chk (
  .clk_sys(clk_sys), .arst_n(arst_n), .cpu_strobe(cpu_strobe), .cpu_slow_req(cpu_slow_req),
  .cpu_slow_addr(cpu_slow_addr), .vid_grant(vid_grant), .ram_ce(ram_ce),
  .ram_addr(ram_addr), .vid_rvalid(vid_rvalid)
);

`default_nettype wire

// File: testbench/iigs_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module iigs_mem_tb;

  logic clk_sys, arst_n, cpu_strobe, we, lc_ram2, lc_we, rd_rom, cx_rom, io_on;
  logic [iigs_mem_pkg::bank_w-1:0] bank;
  logic [iigs_mem_pkg::addr_w-1:0] addr;
  logic [7:0] cpu_dout, shadow, slot_rom_sel, rom_rdata, fast_rdata, slot_rdata;
  logic rom_ce, fast_ce, fast_we, line_start, vid_valid;
  logic [iigs_mem_pkg::addr_w:0] rom_addr;
  logic [iigs_mem_pkg::fast_aw-1:0] fast_addr;
  logic [7:0] fast_wdata, io_select, device_select, cpu_din, vid_data;
  logic [iigs_mem_pkg::slow_aw-1:0] vid_base;

  // vector table, filled from the data file before reset ends
  logic [7:0] v_op [0:63];
  logic [7:0] v_bank [0:63];
  logic [15:0] v_addr [0:63];
  logic [7:0] v_data [0:63];
  logic [7:0] v_shadow [0:63];
  logic [15:0] v_flags [0:63];
  logic [2:0] v_tgt [0:63];
  logic [15:0] v_strb [0:63];
  logic [7:0] v_byte [0:63];
  integer vec_cnt = 0;
  logic vec_ready = 1'b0;
  integer err_cnt = 0;
  integer seed;
  logic line_done;
  logic [7:0] fast_mem [0:65535];

  iigs_mem_top i_dut (.*);

  // external rom answers with the low address byte, one cycle late
  always @(posedge clk_sys)
  begin
    if (rom_ce)
      rom_rdata <= rom_addr[7:0];
    if (fast_ce)
    begin
      if (fast_we)
        fast_mem[fast_addr[15:0]] <= fast_wdata;
      fast_rdata <= fast_mem[fast_addr[15:0]];
    end
  end

  initial
  begin
    clk_sys = 1'b0;
    forever #5 clk_sys = ~clk_sys;
  end

  // run limit scales with the vector count
  initial
  begin
    wait (vec_ready);
    repeat (200 * vec_cnt + 1000) @(posedge clk_sys);
    $display("ERROR: timeout, vectors did not complete in time");
    fail_now();
  end

  task automatic fail_now();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic stop_run(input string why);
    err_cnt++;
    $display("ERROR: %s", why);
    fail_now();
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      fail_now();
    end
  endtask

  task automatic check_strobe(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
      fail_now();
    end
  endtask

  // rom and fast ram targets raise their enable in the strobe cycle
  // a fast ram write also raises fast_we
  function automatic logic [7:0] target_enables(input logic [2:0] tg, input logic wr);
    if (tg == iigs_mem_pkg::tgt_rom)
      return 8'h01;
    else if (tg == iigs_mem_pkg::tgt_fast)
      return wr ? 8'h06 : 8'h02;
    else
      return 8'h00;
  endfunction

  task automatic read_vectors();
    integer fd;
    integer code;
    logic [7:0] op, b, d, sh, by;
    logic [15:0] a, fl, st;
    logic [2:0] tg;
    reg [8*160-1:0] skip;
    fd = $fopen("testbench/mem_vectors.txt", "r");
    if (fd == 0)
      stop_run("cannot open testbench/mem_vectors.txt");
    else
    begin
      while (!$feof(fd))
      begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h\n", op, b, a, d, sh, fl, tg, st, by);
        // comment lines fail the scan and are skipped whole
        if (code == 9 && vec_cnt < 64)
        begin
          v_op[vec_cnt] = op;
          v_bank[vec_cnt] = b;
          v_addr[vec_cnt] = a;
          v_data[vec_cnt] = d;
          v_shadow[vec_cnt] = sh;
          v_flags[vec_cnt] = fl;
          v_tgt[vec_cnt] = tg;
          v_strb[vec_cnt] = st;
          v_byte[vec_cnt] = by;
          vec_cnt++;
        end
        else
          code = $fgets(skip, fd);
      end
      $fclose(fd);
    end
  endtask

  // one cpu strobe, strobes checked in its cycle, read byte one cycle later
  task automatic cpu_access(input logic wr, input logic [7:0] b, input logic [15:0] a,
                            input logic [7:0] d, input logic [7:0] sh, input logic [15:0] fl,
                            input logic [2:0] tg, input logic [15:0] st, input logic [7:0] exp);
    @(posedge clk_sys);
    cpu_strobe <= 1'b1;
    we <= wr;
    bank <= b;
    addr <= a;
    cpu_dout <= d;
    shadow <= sh;
    lc_ram2 <= fl[0];
    lc_we <= fl[1];
    rd_rom <= fl[2];
    cx_rom <= fl[3];
    io_on <= fl[4];
    slot_rom_sel <= fl[15:8];
    @(negedge clk_sys);
    check_strobe("io_select", io_select, st[15:8]);
    check_strobe("device_select", device_select, st[7:0]);
    check_strobe("rom_ce/fast_ce/fast_we", {5'b00000, fast_we, fast_ce, rom_ce},
                 target_enables(tg, wr));
    @(posedge clk_sys);
    cpu_strobe <= 1'b0;
    we <= 1'b0;
    @(negedge clk_sys);
    if (!wr)
      check_byte("cpu_din", cpu_din, exp);
  endtask

  // preload one line of slow ram with an incrementing byte pattern
  task automatic fill_line(input logic [7:0] b, input logic [15:0] a, input logic [7:0] d,
                           input logic [7:0] sh, input logic [15:0] fl);
    int i;
    for (i = 0; i < iigs_mem_pkg::line_bytes; i++)
      cpu_access(1'b1, b, a + 16'(i), d + 8'(i), sh, fl, iigs_mem_pkg::tgt_slow,
                 16'h0000, 8'h00);
  endtask

  task automatic collect_line(input logic [7:0] first);
    int n;
    n = 0;
    while (n < iigs_mem_pkg::line_bytes)
    begin
      @(negedge clk_sys);
      if (vid_valid)
      begin
        check_byte("vid_data", vid_data, first + 8'(n));
        n++;
      end
    end
    line_done = 1'b1;
    // the 40th pulse ends the line
    repeat (4)
    begin
      @(negedge clk_sys);
      if (vid_valid)
        stop_run("vid_valid pulsed after the last byte of the line");
    end
  endtask

  // random cpu reads of the same line while the fetch runs
  task automatic poke_reads(input logic [7:0] b, input logic [15:0] a, input logic [7:0] first,
                            input logic [7:0] sh, input logic [15:0] fl);
    integer gap;
    integer k;
    while (!line_done)
    begin
      gap = {$random(seed)} % 4;
      k = {$random(seed)} % iigs_mem_pkg::line_bytes;
      repeat (gap) @(posedge clk_sys);
      if (!line_done)
        cpu_access(1'b0, b, a + 16'(k), 8'h00, sh, fl, iigs_mem_pkg::tgt_slow,
                   16'h0000, first + 8'(k));
    end
  endtask

  task automatic fetch_line(input logic [7:0] b, input logic [15:0] a, input logic [7:0] first,
                            input logic [7:0] sh, input logic [15:0] fl, input logic busy);
    @(posedge clk_sys);
    line_start <= 1'b1;
    vid_base <= {b[0], a};
    @(posedge clk_sys);
    line_start <= 1'b0;
    line_done = 1'b0;
    if (busy)
    begin
      fork
        collect_line(first);
        poke_reads(b, a, first, sh, fl);
      join
    end
    else
      collect_line(first);
  endtask

  initial
  begin
    int i;
    seed = 81;
    arst_n = 1'b0;
    cpu_strobe = 1'b0;
    we = 1'b0;
    bank = 8'h00;
    addr = 16'h0000;
    cpu_dout = 8'h00;
    shadow = 8'hff;
    {lc_ram2, lc_we, rd_rom, cx_rom, io_on} = 5'b00000;
    slot_rom_sel = 8'hff;
    rom_rdata = 8'h00;
    fast_rdata = 8'h00;
    slot_rdata = 8'h5c;
    line_start = 1'b0;
    vid_base = '0;
    line_done = 1'b0;
    for (i = 0; i < 65536; i++)
      fast_mem[i] = i[7:0] ^ i[15:8];
    read_vectors();
    vec_ready = 1'b1;
    repeat (15) @(posedge clk_sys);
    // outputs idle while reset is held
    @(negedge clk_sys);
    check_strobe("reset outputs", {3'b000, vid_valid, rom_ce, fast_ce, fast_we, 1'b0}, 8'h00);
    check_strobe("io_select", io_select, 8'h00);
    check_strobe("device_select", device_select, 8'h00);
    @(posedge clk_sys);
    arst_n <= 1'b1;
    for (i = 0; i < vec_cnt; i++)
    begin
      case (v_op[i])
        8'h00, 8'h01:
          cpu_access(v_op[i] == 8'h00, v_bank[i], v_addr[i], v_data[i], v_shadow[i],
                     v_flags[i], v_tgt[i], v_strb[i], v_byte[i]);
        8'h02, 8'h03:
        begin
          fill_line(v_bank[i], v_addr[i], v_data[i], v_shadow[i], v_flags[i]);
          fetch_line(v_bank[i], v_addr[i], v_byte[i], v_shadow[i], v_flags[i],
                     v_op[i] == 8'h03);
        end
        default:
          stop_run("unknown op code in the vector file");
      endcase
    end
    repeat (4) @(posedge clk_sys);
    if (err_cnt == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/mem_vectors.txt
# op bank addr data shadow flags tgt strobes byte, all hex; op 0 write 1 read 2 line 3 line+cpu
# flags: 15:8 slot_rom_sel, 4 io_on, 3 cx_rom, 2 rd_rom, 1 lc_we, 0 lc_ram2; strobes io:dev
01 fe 1234 00 00 0000 1 0000 34
01 00 e05a 00 00 0000 1 0000 5a
00 05 8001 c3 00 0000 2 0000 00
01 05 8001 00 00 0000 2 0000 c3
00 00 0400 a7 00 0000 2 0000 00
01 e0 0400 00 00 0000 3 0000 a7
00 00 0400 3e 01 0000 2 0000 00
01 e0 0400 00 01 0000 3 0000 a7
01 00 0400 00 01 0000 2 0000 3e
00 e0 d123 69 ff 0001 3 0000 00
01 e0 c123 00 ff 0000 3 0000 69
01 e0 d123 00 ff 0001 3 0000 69
01 40 1000 00 00 0000 0 0000 80
01 00 c0f0 00 00 7f00 1 0080 f0
01 00 c700 00 00 7f00 1 8000 00
01 00 c400 00 00 7f00 1 0000 00
01 01 c0f0 00 40 7f10 4 0080 5c
02 e1 2000 10 00 0000 3 0000 10
03 e0 5000 90 00 0000 3 0000 90

// File: flist.f
logic/iigs_mem_pkg.sv
logic/bank_decoder.sv
logic/slow_ram_arbiter.sv
logic/slow_ram.sv
logic/video_fetch.sv
logic/iigs_mem_top.sv
testbench/iigs_mem_chk.sv
testbench/iigs_mem_tb.sv
